/* project.f */
rtl/wave_pkg.sv
rtl/dac_pkg.sv
rtl/sample_if.sv
rtl/phase_accumulator.sv
rtl/sine_approx.sv
rtl/waveform_shaper.sv
rtl/sample_fifo.sv
rtl/dac_pacer.sv
rtl/signal_gen_top.sv
sim/signal_gen_tb.sv

/* rtl/dac_pacer.sv */
module dac_pacer #
(
    parameter int OUT_DIV = 4
)
(
    input  logic               clk,
    input  logic               aresetn,
    sample_if.sink             in,
    output logic               pop,
    output logic               dac_strobe,
    output dac_pkg::dac_code_t dac_code,
    output logic               dac_last
);

    localparam int CNT_W = $clog2(OUT_DIV);

    dac_pkg::pacer_state_e state;
    logic [CNT_W-1:0]      wait_cnt;    // cycles left before the next pop
    wave_pkg::sample_t     scaled;
    dac_pkg::dac_code_t    code_next;

    assign pop       = (state == dac_pkg::PACE_IDLE) && in.strobe;
    assign scaled    = in.sample >>> (wave_pkg::SAMPLE_W - dac_pkg::DAC_W);
    assign code_next = dac_pkg::dac_code_t'(scaled + wave_pkg::sample_t'(dac_pkg::DAC_MID));

    always_ff @(posedge clk)
    begin
        if (!aresetn)
        begin
            state      <= dac_pkg::PACE_IDLE;
            wait_cnt   <= '0;
            dac_strobe <= 1'b0;
            dac_last   <= 1'b0;
        end
        else
        begin
            dac_strobe <= pop;
            dac_last   <= pop && in.last;
            case (state)
                dac_pkg::PACE_IDLE:
                    if (pop)
                    begin
                        state    <= dac_pkg::PACE_WAIT;
                        wait_cnt <= CNT_W'(OUT_DIV - 2);    // pop cycle counts as one
                    end
                default:
                    if (wait_cnt == '0)
                        state <= dac_pkg::PACE_IDLE;
                    else
                        wait_cnt <= wait_cnt - 1'b1;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (pop)
            dac_code <= code_next;
    end

    for (genvar k = 1; k < OUT_DIV; k++)
    begin : g_gap
        strobe_gap: assert property (@(posedge clk) disable iff (!aresetn)
            dac_strobe |-> !$past(dac_strobe, k));
    end

endmodule

/* rtl/dac_pkg.sv */
// #########################################################################
// converter side: code format and pacer states
// #########################################################################

package dac_pkg;

    localparam int DAC_W = 14;    // converter resolution

    // offset binary, zero volts at mid scale
    typedef logic [DAC_W-1:0] dac_code_t;

    localparam int DAC_MID = 1 << (DAC_W - 1);    // 8192

    // #####################################################################
    // pacer states
    // #####################################################################

    typedef enum logic
    {
        PACE_IDLE = 1'b0,    // ready to take a sample
        PACE_WAIT = 1'b1     // holding off until the next dac slot
    } pacer_state_e;

endpackage

/* rtl/phase_accumulator.sv */
module phase_accumulator
(
    input  logic             clk,
    input  logic             aresetn,
    input  logic             start,
    input  wave_pkg::phase_t freq_word,
    input  logic [7:0]       burst_len,
    output logic             busy,
    output logic             phase_strobe,
    output wave_pkg::phase_t phase,
    output logic             phase_first,
    output logic             phase_last
);

    wave_pkg::phase_t freq_q;    // frequency word of the running burst
    logic [7:0]       remain;    // phases still to come after the current one

    always_ff @(posedge clk)
    begin
        if (!aresetn)
        begin
            busy         <= 1'b0;
            phase_strobe <= 1'b0;
            phase_first  <= 1'b0;
            phase_last   <= 1'b0;
            remain       <= 8'd0;
        end
        else if (busy)
        begin
            phase_first <= 1'b0;
            if (remain == 8'd0)
            begin
                busy         <= 1'b0;
                phase_strobe <= 1'b0;
                phase_last   <= 1'b0;
            end
            else
            begin
                remain     <= remain - 8'd1;
                phase_last <= (remain == 8'd1);
            end
        end
        else if (start && burst_len != 8'd0)
        begin
            busy         <= 1'b1;
            phase_strobe <= 1'b1;
            phase_first  <= 1'b1;
            phase_last   <= (burst_len == 8'd1);
            remain       <= burst_len - 8'd1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!busy && start)
        begin
            freq_q <= freq_word;
            phase  <= {wave_pkg::PHASE_W{1'b0}};    // every burst starts at phase 0
        end
        else if (busy)
            phase <= phase + freq_q;
    end

    last_ends_burst: assert property (@(posedge clk) disable iff (!aresetn)
        phase_strobe |=> (phase_strobe == !$past(phase_last)));

endmodule

/* rtl/sample_fifo.sv */
module sample_fifo #
(
    parameter int FIFO_DEPTH = 16
)
(
    input  logic     clk,
    input  logic     aresetn,
    sample_if.sink   in,
    sample_if.source out,
    input  logic     pop,
    output logic     overflow
);

    localparam int AW = $clog2(FIFO_DEPTH);

    typedef struct packed
    {
        logic              first;
        logic              last;
        wave_pkg::sample_t sample;
    } entry_t;

    entry_t      mem [FIFO_DEPTH];
    entry_t      rd_entry;
    logic [AW:0] wr_ptr;    // extra msb tells full from empty
    logic [AW:0] rd_ptr;
    logic [AW:0] count;
    logic        full;
    logic        empty;
    logic        do_write;
    logic        do_read;

    assign count    = wr_ptr - rd_ptr;
    assign empty    = (wr_ptr == rd_ptr);
    assign full     = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign do_write = in.strobe && !full;    // no back-pressure, a full fifo drops
    assign do_read  = pop && !empty;

    always_ff @(posedge clk)
    begin
        if (!aresetn)
        begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            overflow <= 1'b0;
        end
        else
        begin
            if (do_write)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_read)
                rd_ptr <= rd_ptr + 1'b1;
            if (in.strobe && full)
                overflow <= 1'b1;    // sticky until reset
        end
    end

    always_ff @(posedge clk)
    begin
        if (do_write)
            mem[wr_ptr[AW-1:0]] <= '{first: in.first, last: in.last, sample: in.sample};
    end

    assign rd_entry   = mem[rd_ptr[AW-1:0]];
    assign out.strobe = !empty;    // head entry available
    assign out.sample = rd_entry.sample;
    assign out.first  = rd_entry.first;
    assign out.last   = rd_entry.last;

    pop_when_ready: assert property (@(posedge clk) disable iff (!aresetn)
        pop |-> out.strobe);

    count_in_range: assert property (@(posedge clk) disable iff (!aresetn)
        count <= FIFO_DEPTH);

endmodule

/* rtl/sample_if.sv */
// single-cycle sample stream, no back-pressure
interface sample_if;

    logic              strobe;    // sample valid this cycle
    wave_pkg::sample_t sample;
    logic              first;     // first sample of a burst
    logic              last;      // last sample of a burst

    modport source
    (
        output strobe,
        output sample,
        output first,
        output last
    );

    modport sink
    (
        input strobe,
        input sample,
        input first,
        input last
    );

endinterface

/* rtl/signal_gen_top.sv */
module signal_gen_top #
(
    parameter int FIFO_DEPTH = 16,
    parameter int OUT_DIV    = 4
)
(
    input  logic                 clk,
    input  logic                 aresetn,
    input  logic                 start,
    input  wave_pkg::wave_kind_e wave_kind,
    input  wave_pkg::phase_t     freq_word,
    input  logic [7:0]           burst_len,
    output logic                 busy,
    output logic                 overflow,
    output logic                 dac_strobe,
    output dac_pkg::dac_code_t   dac_code,
    output logic                 dac_last
);

    wave_pkg::wave_kind_e        kind_q;    // kind of the running burst
    logic                        phase_strobe;
    logic [wave_pkg::PHASE_W-1:0] phase;
    logic                        phase_first;
    logic                        phase_last;
    wave_pkg::sample_t           sine;
    logic                        pop;

    sample_if shaped ();      // shaper -> fifo
    sample_if buffered ();    // fifo -> pacer

    always_ff @(posedge clk)
    begin
        if (!aresetn)
            kind_q <= wave_pkg::WAVE_SINE;
        else if (start && !busy)
            kind_q <= wave_kind;
    end

    // #####################################################################
    // producer chain
    // #####################################################################

    phase_accumulator u_acc
    (
        .clk          (clk),
        .aresetn      (aresetn),
        .start        (start),
        .freq_word    (freq_word),
        .burst_len    (burst_len),
        .busy         (busy),
        .phase_strobe (phase_strobe),
        .phase        (phase),
        .phase_first  (phase_first),
        .phase_last   (phase_last)
    );

    sine_approx u_sine
    (
        .clk     (clk),
        .aresetn (aresetn),
        .phase   (phase),
        .sine    (sine)
    );

    waveform_shaper u_shaper
    (
        .clk          (clk),
        .aresetn      (aresetn),
        .wave_kind    (kind_q),
        .phase_strobe (phase_strobe),
        .phase        (phase),
        .phase_first  (phase_first),
        .phase_last   (phase_last),
        .sine         (sine),
        .out          (shaped.source)
    );

    // #####################################################################
    // buffer and dac side
    // #####################################################################

    sample_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo
    (
        .clk      (clk),
        .aresetn  (aresetn),
        .in       (shaped.sink),
        .out      (buffered.source),
        .pop      (pop),
        .overflow (overflow)
    );

    dac_pacer #(.OUT_DIV(OUT_DIV)) u_pacer
    (
        .clk        (clk),
        .aresetn    (aresetn),
        .in         (buffered.sink),
        .pop        (pop),
        .dac_strobe (dac_strobe),
        .dac_code   (dac_code),
        .dac_last   (dac_last)
    );

endmodule

/* rtl/sine_approx.sv */
// sin(2*pi*p) ~ x*(1-x) on each half turn, scaled to a peak of 16384
module sine_approx
(
    input  logic              clk,
    input  logic              aresetn,
    input  wave_pkg::phase_t  phase,
    output wave_pkg::sample_t sine
);

    localparam int SHIFT = wave_pkg::PHASE_W - 2;    // product / 2^14

    logic [wave_pkg::PHASE_W-2:0]   x_q;     // position inside the half turn
    logic [wave_pkg::PHASE_W-1:0]   xc_q;    // 32768 - x
    logic                           neg_q;   // second half turn
    logic [2*wave_pkg::PHASE_W-2:0] prod;
    wave_pkg::sample_t              mag;

    // #####################################################################
    // stage one: split the phase
    // #####################################################################

    always_ff @(posedge clk)
    begin
        if (!aresetn)
        begin
            x_q   <= '0;
            xc_q  <= '0;
            neg_q <= 1'b0;
        end
        else
        begin
            x_q   <= phase[wave_pkg::PHASE_W-2:0];
            xc_q  <= {1'b1, {(wave_pkg::PHASE_W-1){1'b0}}}
                     - {1'b0, phase[wave_pkg::PHASE_W-2:0]};
            neg_q <= phase[wave_pkg::PHASE_W-1];
        end
    end

    // #####################################################################
    // stage two: parabola and sign
    // #####################################################################

    assign prod = x_q * xc_q;    // peaks at 2^28 for x = 16384
    assign mag  = wave_pkg::sample_t'(prod >> SHIFT);

    always_ff @(posedge clk)
    begin
        if (!aresetn)
            sine <= '0;
        else
            sine <= neg_q ? -mag : mag;
    end

endmodule

/* rtl/wave_pkg.sv */
// #########################################################################
// generator side: phase and sample words, waveform kinds
// #########################################################################

package wave_pkg;

    localparam int PHASE_W  = 16;    // accumulator width, one full turn
    localparam int SAMPLE_W = 16;    // signed sample width

    // unsigned phase word, wraps once per period
    typedef logic [PHASE_W-1:0] phase_t;

    // two's complement sample, full scale +/- 2^(SAMPLE_W-1)
    typedef logic signed [SAMPLE_W-1:0] sample_t;

    // #####################################################################
    // waveform kinds
    // #####################################################################

    typedef enum logic [1:0]
    {
        WAVE_SINE     = 2'd0,    // parabolic approximation
        WAVE_SAW      = 2'd1,    // rising ramp
        WAVE_SAW_REV  = 2'd2,    // falling ramp, saturated at the top
        WAVE_TRIANGLE = 2'd3     // folded ramp
    } wave_kind_e;

endpackage

/* rtl/waveform_shaper.sv */
module waveform_shaper
(
    input  logic                 clk,
    input  logic                 aresetn,
    input  wave_pkg::wave_kind_e wave_kind,
    input  logic                 phase_strobe,
    input  wave_pkg::phase_t     phase,
    input  logic                 phase_first,
    input  logic                 phase_last,
    input  wave_pkg::sample_t    sine,
    sample_if.source             out
);

    localparam wave_pkg::sample_t S_MAX =
        wave_pkg::sample_t'((1 << (wave_pkg::SAMPLE_W - 1)) - 1);
    localparam wave_pkg::sample_t S_MIN = ~S_MAX;
    localparam logic signed [wave_pkg::SAMPLE_W+1:0] FOLD_OFS = 1 << (wave_pkg::SAMPLE_W - 1);

    logic [1:0]           stb_d;      // tags delayed to match the sine pipeline
    logic [1:0]           first_d;
    logic [1:0]           last_d;
    wave_pkg::phase_t     ph_d1;
    wave_pkg::phase_t     ph_d2;
    wave_pkg::wave_kind_e kind_d1;
    wave_pkg::wave_kind_e kind_d2;

    wave_pkg::sample_t                    s;
    logic signed [wave_pkg::SAMPLE_W:0]   s_wide;
    logic signed [wave_pkg::SAMPLE_W:0]   abs_s;     // 0 .. 32768
    logic signed [wave_pkg::SAMPLE_W+1:0] fold_w;    // 2|s| - 32768
    wave_pkg::sample_t                    saw_rev;
    wave_pkg::sample_t                    fold_s;
    wave_pkg::sample_t                    shaped;

    always_ff @(posedge clk)
    begin
        if (!aresetn)
        begin
            stb_d      <= 2'b00;
            first_d    <= 2'b00;
            last_d     <= 2'b00;
            out.strobe <= 1'b0;
            out.first  <= 1'b0;
            out.last   <= 1'b0;
        end
        else
        begin
            stb_d      <= {stb_d[0], phase_strobe};
            first_d    <= {first_d[0], phase_first};
            last_d     <= {last_d[0], phase_last};
            out.strobe <= stb_d[1];
            out.first  <= first_d[1];
            out.last   <= last_d[1];
        end
    end

    always_ff @(posedge clk)
    begin
        ph_d1      <= phase;
        ph_d2      <= ph_d1;
        kind_d1    <= wave_kind;
        kind_d2    <= kind_d1;
        out.sample <= shaped;
    end

    assign s       = wave_pkg::sample_t'(ph_d2);
    assign s_wide  = {s[wave_pkg::SAMPLE_W-1], s};
    assign abs_s   = s_wide[wave_pkg::SAMPLE_W] ? -s_wide : s_wide;
    assign fold_w  = {abs_s, 1'b0} - FOLD_OFS;
    assign saw_rev = (s == S_MIN) ? S_MAX : -s;    // -(-32768) does not fit
    assign fold_s  = (fold_w > S_MAX) ? S_MAX : fold_w[wave_pkg::SAMPLE_W-1:0];

    always_comb
    begin
        case (kind_d2)
            wave_pkg::WAVE_SINE:    shaped = sine;
            wave_pkg::WAVE_SAW:     shaped = s;
            wave_pkg::WAVE_SAW_REV: shaped = saw_rev;
            default:                shaped = fold_s;    // triangle
        endcase
    end

    kind_known: assert property (@(posedge clk) disable iff (!aresetn)
        phase_strobe |-> !$isunknown(wave_kind));

endmodule

/* run.sh */
#!/bin/sh
# build and run the signal generator testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f project.f \
    --top-module signal_gen_tb -Mdir obj_dir -o signal_gen_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_dir/signal_gen_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '^\*\* PASS \*\*$' sim.log; then
    exit 0
fi
echo "pass line not found in sim.log"
exit 1

/* sim/signal_gen_tb.sv */
module signal_gen_tb;

    localparam int FIFO_DEPTH   = 16;
    localparam int OUT_DIV      = 4;
    localparam int CLK_PERIOD   = 40;
    localparam int DRIVE_DELAY  = 5;
    localparam int RESET_CYCLES = 16;
    localparam int QUIET_CYCLES = 4 * OUT_DIV;    // longer than pipeline plus pacer slot
    localparam int TOTAL_LEN    = 12 + 20 + 3 * 16 + 10 + 40;
    localparam int WATCHDOG_TIME = TOTAL_LEN * OUT_DIV * CLK_PERIOD + 40000;

    logic                 clk = 1'b0;
    logic                 aresetn;
    logic                 start;
    wave_pkg::wave_kind_e wave_kind;
    wave_pkg::phase_t     freq_word;
    logic [7:0]           burst_len;
    logic                 busy;
    logic                 overflow;
    logic                 dac_strobe;
    dac_pkg::dac_code_t   dac_code;
    logic                 dac_last;

    dac_pkg::dac_code_t got_code [$];    // codes seen by the monitor
    logic               got_last [$];
    logic [31:0]        rng = 32'd88;
    int                 cycle = 0;
    int                 last_cycle = 0;
    logic               seen_strobe = 1'b0;

    signal_gen_top #(.FIFO_DEPTH(FIFO_DEPTH), .OUT_DIV(OUT_DIV)) dut
    (
        .clk        (clk),
        .aresetn    (aresetn),
        .start      (start),
        .wave_kind  (wave_kind),
        .freq_word  (freq_word),
        .burst_len  (burst_len),
        .busy       (busy),
        .overflow   (overflow),
        .dac_strobe (dac_strobe),
        .dac_code   (dac_code),
        .dac_last   (dac_last)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ########################################################################
    // reporting and compare
    // ########################################################################

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1);
    endtask

    task automatic check_code(input string name, input dac_pkg::dac_code_t got,
                              input dac_pkg::dac_code_t exp);
        if (got !== exp)
            abort_run($sformatf("FAIL %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
            abort_run($sformatf("FAIL %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    // ########################################################################
    // reference model and random words
    // ########################################################################

    function automatic wave_pkg::sample_t model_sample(input wave_pkg::wave_kind_e kind,
                                                       input wave_pkg::phase_t p);
        int s;
        int x;
        int mag;
        int r;
        s   = p[15] ? int'(p) - 65536 : int'(p);
        x   = int'(p) & 32767;
        mag = (x * (32768 - x)) >>> 14;
        case (kind)
            wave_pkg::WAVE_SINE:    r = p[15] ? -mag : mag;
            wave_pkg::WAVE_SAW:     r = s;
            wave_pkg::WAVE_SAW_REV: r = -s;
            default:                r = 2 * (s < 0 ? -s : s) - 32768;
        endcase
        if (r > 32767)
            r = 32767;    // reverse saw and triangle top
        return wave_pkg::sample_t'(r);
    endfunction

    function automatic dac_pkg::dac_code_t model_code(input wave_pkg::sample_t v);
        int t;
        t = (int'(v) >>> 2) + dac_pkg::DAC_MID;
        return dac_pkg::dac_code_t'(t);
    endfunction

    function automatic logic [31:0] xorshift(input logic [31:0] v);
        logic [31:0] n;
        n = v ^ (v << 13);
        n = n ^ (n >> 17);
        n = n ^ (n << 5);
        return n;
    endfunction

    function automatic wave_pkg::phase_t random_word();
        rng = xorshift(rng);
        return rng[15:0];
    endfunction

    // odd multiple of 0x1000 so that 16 phases visit every step including 0x8000
    function automatic wave_pkg::phase_t half_turn_word();
        rng = xorshift(rng);
        return {rng[15:13], 1'b1, 12'h000};
    endfunction

    // ########################################################################
    // monitor, driving and burst checks
    // ########################################################################

    always @(negedge clk)
    begin
        cycle = cycle + 1;
        if (aresetn && dac_strobe)
        begin
            if (seen_strobe && (cycle - last_cycle) < OUT_DIV)
                abort_run($sformatf("dac_strobe pulses only %0d cycles apart",
                                    cycle - last_cycle));
            seen_strobe = 1'b1;
            last_cycle  = cycle;
            got_code.push_back(dac_code);
            got_last.push_back(dac_last);
        end
    end

    task automatic launch(input wave_pkg::wave_kind_e kind, input wave_pkg::phase_t freq,
                          input logic [7:0] len);
        @(posedge clk);
        #DRIVE_DELAY;
        wave_kind = kind;
        freq_word = freq;
        burst_len = len;
        start     = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;
        start = 1'b0;
    endtask

    // wait for busy to drop and then for the dac side to go quiet
    task automatic drain();
        int quiet;
        quiet = 0;
        do
            @(negedge clk);
        while (busy);
        while (quiet < QUIET_CYCLES)
        begin
            @(negedge clk);
            quiet = dac_strobe ? 0 : quiet + 1;
        end
    endtask

    task automatic check_burst(input wave_pkg::wave_kind_e kind, input wave_pkg::phase_t freq,
                               input int len);
        wave_pkg::phase_t p;
        if (got_code.size() != len)
            abort_run($sformatf("burst of %0d samples gave %0d codes", len, got_code.size()));
        for (int i = 0; i < len; i++)
        begin
            p = wave_pkg::phase_t'(i * int'(freq));
            check_code("dac_code", got_code[i], model_code(model_sample(kind, p)));
            check_flag("dac_last", got_last[i], i == len - 1);
        end
        check_flag("overflow", overflow, 1'b0);
    endtask

    task automatic run_burst(input wave_pkg::wave_kind_e kind, input wave_pkg::phase_t freq,
                             input int len);
        got_code.delete();
        got_last.delete();
        launch(kind, freq, len[7:0]);
        drain();
        check_burst(kind, freq, len);
    endtask

    // ########################################################################
    // directed tests
    // ########################################################################

    task automatic test_idle();
        check_flag("busy", busy, 1'b0);
        check_flag("overflow", overflow, 1'b0);
        check_flag("dac_strobe", dac_strobe, 1'b0);
        repeat (20) @(negedge clk);
        check_flag("busy", busy, 1'b0);
        check_flag("overflow", overflow, 1'b0);
        if (got_code.size() != 0)
            abort_run("dac codes appeared without any start");
    endtask

    task automatic test_sine();
        run_burst(wave_pkg::WAVE_SINE, 16'h1000, 12);
        run_burst(wave_pkg::WAVE_SINE, random_word(), 20);
    endtask

    task automatic test_other_kinds();
        run_burst(wave_pkg::WAVE_SAW, half_turn_word(), 16);
        run_burst(wave_pkg::WAVE_SAW_REV, half_turn_word(), 16);
        run_burst(wave_pkg::WAVE_TRIANGLE, half_turn_word(), 16);
    endtask

    task automatic test_ignored_start();
        wave_pkg::phase_t freq;
        freq = random_word();
        got_code.delete();
        got_last.delete();
        launch(wave_pkg::WAVE_SAW, freq, 8'd10);
        repeat (2) @(posedge clk);
        launch(wave_pkg::WAVE_SINE, freq ^ 16'h5a5a, 8'd5);    // lands mid burst
        drain();
        check_burst(wave_pkg::WAVE_SAW, freq, 10);
    endtask

    task automatic test_overflow();
        wave_pkg::phase_t freq;
        int               j;
        freq = random_word();
        check_flag("overflow", overflow, 1'b0);
        got_code.delete();
        got_last.delete();
        launch(wave_pkg::WAVE_SAW, freq, 8'd40);
        drain();
        check_flag("overflow", overflow, 1'b1);
        if (got_code.size() == 0 || got_code.size() >= 40)
            abort_run($sformatf("overrun burst gave %0d codes", got_code.size()));
        check_code("dac_code", got_code[0], model_code(model_sample(wave_pkg::WAVE_SAW, 0)));
        j = 0;
        foreach (got_code[i])
        begin
            while (j < 40 && model_code(model_sample(wave_pkg::WAVE_SAW,
                   wave_pkg::phase_t'(j * int'(freq)))) !== got_code[i])
                j++;
            if (j >= 40)
                abort_run("overrun codes are not an in-order part of the burst");
            j++;
        end
        repeat (2 * QUIET_CYCLES) @(negedge clk);
        check_flag("overflow", overflow, 1'b1);    // sticky
    endtask

    initial
    begin
        #WATCHDOG_TIME;
        abort_run("watchdog expired before the tests finished");
    end

    initial
    begin
        aresetn   = 1'b0;
        start     = 1'b0;
        wave_kind = wave_pkg::WAVE_SINE;
        freq_word = '0;
        burst_len = 8'd0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        aresetn = 1'b1;
        test_idle();
        test_sine();
        test_other_kinds();
        test_ignored_start();
        test_overflow();
        $display("** PASS **");
        $finish;
    end

endmodule
